/* src/uart_frame_pkg.sv */
package uart_frame_pkg;

  // --------------------
  // serial frame format
  // --------------------

  // one start bit, 7 or 8 data bits lsb first, optional parity, one stop bit

  localparam int DATA_W = 8;      // widest data field, also the byte register width

  // the receiver runs off a strobe at 16x the bit rate
  localparam int OVERSAMPLE = 16; // baud ticks per bit time

  // a falling edge must stay low this many ticks to count as a start bit,
  // which also puts the sample phase near the middle of each later bit
  localparam int MID_START = 8;   // ticks from start-bit edge to its middle

  // --------------------
  // line levels
  // --------------------

  // idle and stop are mark (high), start is space (low)
  localparam logic LINE_IDLE  = 1'b1;
  localparam logic LINE_START = 1'b0;

endpackage

/* src/uart_rx_pkg.sv */
package uart_rx_pkg;

  import uart_frame_pkg::*;

  // --------------------
  // counter widths
  // --------------------

  localparam int TICK_W    = $clog2(OVERSAMPLE); // counts ticks within a bit
  localparam int BIT_CNT_W = 4;                  // up to 9 bits incl. parity

  // --------------------
  // sample timing
  // --------------------

  // last tick of a bit period, i.e. one full bit after the start-bit middle
  localparam logic [TICK_W-1:0] SAMPLE_POINT = TICK_W'(OVERSAMPLE - 1);

  // give up waiting for a high line after the stop bit at this count
  localparam logic [TICK_W-1:0] WAIT_LIMIT = TICK_W'(6);

  localparam int SHIFT_W = DATA_W + 1; // data plus parity bit

  // --------------------
  // frame fsm states
  // --------------------

  typedef enum logic [1:0] {
    ST_IDLE, // hunting for a start bit
    ST_DATA, // clocking data and parity bits in
    ST_STOP, // checking the stop bit
    ST_WAIT  // waiting for the line to return high
  } rx_state_t;

endpackage

/* src/rx_filter.sv */
module rx_filter (
  input  logic clk,
  input  logic aresetn,
  input  logic baud_tick, // 16x bit-rate strobe
  input  logic rx,        // raw serial line
  output logic rx_filtered
);

  logic [2:0] samples_q; // [2] newest, [0] oldest

  // --------------------
  // sample history
  // --------------------

  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      samples_q <= 3'b111; // line idles high
    end
    else if (baud_tick)
    begin
      samples_q <= {rx, samples_q[2:1]}; // shift towards bit 0
    end
  end

  // 2 of 3 vote, a single low or high tick is swallowed
  assign rx_filtered = (samples_q[0] & samples_q[1]) |
                       (samples_q[1] & samples_q[2]) |
                       (samples_q[0] & samples_q[2]);

endmodule

/* src/rx_frame_fsm.sv */
module rx_frame_fsm
  import uart_frame_pkg::*;
  import uart_rx_pkg::*;
(
  input  logic clk,
  input  logic aresetn,
  input  logic baud_tick,
  input  logic rx_filtered,
  input  logic bit8,        // 1 = 8 data bits, 0 = 7
  input  logic parity_en,
  output logic frame_start, // idle -> data
  output logic sample_stb,  // every data and parity bit
  output logic parity_stb,  // parity bit only
  output logic byte_done,   // last bit taken
  output logic stop_bad     // stop bit sampled low
);

  rx_state_t              state_q;
  logic [TICK_W-1:0]      tick_cnt_q; // ticks within current bit
  logic [BIT_CNT_W-1:0]   bit_cnt_q;  // bits sampled so far
  logic [BIT_CNT_W-1:0]   last_bit_q; // bit count that ends the data phase
  logic                   at_mid;
  logic                   at_sample;
  logic                   at_wait_lim;
  logic                   tick_clr;

  assign at_mid      = (tick_cnt_q == TICK_W'(MID_START));
  assign at_sample   = (tick_cnt_q == SAMPLE_POINT);
  assign at_wait_lim = (tick_cnt_q == WAIT_LIMIT);

  // idle restarts the count on a high line, so only a held low reaches the middle
  assign tick_clr = ((state_q == ST_IDLE) && (rx_filtered || at_mid)) ||
                    ((state_q == ST_WAIT) && at_wait_lim);

  // --------------------
  // strobes
  // --------------------

  assign frame_start = baud_tick && (state_q == ST_IDLE) && at_mid && !rx_filtered;
  assign byte_done   = baud_tick && (state_q == ST_DATA) && (bit_cnt_q == last_bit_q);
  assign sample_stb  = baud_tick && (state_q == ST_DATA) && at_sample &&
                       (bit_cnt_q != last_bit_q);
  assign parity_stb  = sample_stb && parity_en &&
                       (bit_cnt_q == last_bit_q - 1'b1); // final bit of the frame
  assign stop_bad    = baud_tick && (state_q == ST_STOP) && at_sample && !rx_filtered;

  // --------------------
  // counters
  // --------------------

  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      tick_cnt_q <= '0;
      bit_cnt_q  <= '0;
      last_bit_q <= BIT_CNT_W'(DATA_W); // 8N1
    end
    else
    begin
      if (baud_tick)
      begin
        if (tick_clr)
          tick_cnt_q <= '0;
        else
          tick_cnt_q <= tick_cnt_q + 1'b1; // wraps once per bit
      end
      if (frame_start)
      begin
        bit_cnt_q  <= '0;
        // 7..9 bits depending on data width and parity
        last_bit_q <= BIT_CNT_W'(DATA_W - 1) + BIT_CNT_W'(bit8) + BIT_CNT_W'(parity_en);
      end
      else if (sample_stb)
      begin
        bit_cnt_q <= bit_cnt_q + 1'b1;
      end
    end
  end

  // --------------------
  // frame state machine
  // --------------------

  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      state_q <= ST_IDLE;
    end
    else if (baud_tick)
    begin
      case (state_q)
        ST_IDLE:
          if (frame_start)
            state_q <= ST_DATA;
        ST_DATA:
          if (bit_cnt_q == last_bit_q)
            state_q <= ST_STOP; // one tick after the last sample
        ST_STOP:
          if (at_sample)
            state_q <= ST_WAIT;
        ST_WAIT:
          if (rx_filtered || at_wait_lim)
            state_q <= ST_IDLE; // line back high, or a break holding it low
        default:
          state_q <= ST_IDLE;
      endcase
    end
  end

endmodule

/* src/rx_data_path.sv */
module rx_data_path
  import uart_frame_pkg::*;
  import uart_rx_pkg::*;
(
  input  logic              clk,
  input  logic              aresetn,
  input  logic              sample_stb,
  input  logic              parity_stb,
  input  logic              frame_start,
  input  logic              rx_filtered,
  input  logic              bit8,
  input  logic              parity_en,
  input  logic              odd,        // 1 = odd parity, 0 = even
  output logic [DATA_W-1:0] rx_data,
  output logic              parity_bad
);

  logic [SHIFT_W-1:0] shift_q; // data right-justified once the frame is in
  logic               par_q;   // running xor of the data bits

  // --------------------
  // shift register
  // --------------------

  // entry point set by the format so the lsb lands in bit 0
  always_ff @(posedge clk)
  begin
    if (frame_start)
    begin
      shift_q <= '0;
    end
    else if (sample_stb)
    begin
      case ({bit8, parity_en})
        2'b00:   shift_q <= {2'b00, rx_filtered, shift_q[6:1]}; // 7 bits
        2'b11:   shift_q <= {rx_filtered, shift_q[8:1]};        // 9 bits
        default: shift_q <= {1'b0, rx_filtered, shift_q[7:1]};  // 8 bits
      endcase
    end
  end

  // in 7-bit mode bit 7 is empty or holds the parity bit
  assign rx_data = {bit8 & shift_q[7], shift_q[6:0]};

  // --------------------
  // parity check
  // --------------------

  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
      par_q <= 1'b0;
    else if (frame_start)
      par_q <= 1'b0;
    else if (sample_stb && !parity_stb)
      par_q <= par_q ^ rx_filtered; // parity bit itself stays out
  end

  // even parity wants data ^ parity == 0, odd wants 1
  assign parity_bad = parity_stb && (par_q ^ rx_filtered ^ odd);

endmodule

/* src/rx_ctrl_regs.sv */
module rx_ctrl_regs
  import uart_frame_pkg::*;
(
  input  logic              clk,
  input  logic              aresetn,
  input  logic              cfg_wr,        // load format, only between frames
  input  logic              cfg_bit8,
  input  logic              cfg_parity_en,
  input  logic              cfg_odd,
  input  logic              byte_done,
  input  logic [DATA_W-1:0] rx_data,
  input  logic              parity_bad,
  input  logic              stop_bad,
  input  logic              read_rx_byte,
  input  logic              clear_parity,
  input  logic              clear_framing_error,
  output logic              bit8,
  output logic              parity_en,
  output logic              odd,
  output logic [DATA_W-1:0] rx_byte,
  output logic              receive_full,
  output logic              overflow,
  output logic              parity_err,
  output logic              framing_error
);

  // --------------------
  // format register
  // --------------------

  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      bit8      <= 1'b1; // 8N1 out of reset
      parity_en <= 1'b0;
      odd       <= 1'b0;
    end
    else if (cfg_wr)
    begin
      bit8      <= cfg_bit8;
      parity_en <= cfg_parity_en;
      odd       <= cfg_odd;
    end
  end

  // --------------------
  // holding register
  // --------------------

  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      rx_byte      <= '0;
      receive_full <= 1'b0;
      overflow     <= 1'b0;
    end
    else
    begin
      if (byte_done && !receive_full)
        rx_byte <= rx_data; // a byte arriving while full is dropped
      if (read_rx_byte)
      begin
        receive_full <= 1'b0; // read beats a new byte
        overflow     <= 1'b0;
      end
      else if (byte_done)
      begin
        receive_full <= 1'b1;
        overflow     <= overflow | receive_full;
      end
    end
  end

  // --------------------
  // sticky error flags
  // --------------------

  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      parity_err    <= 1'b0;
      framing_error <= 1'b0;
    end
    else
    begin
      if (clear_parity)
        parity_err <= 1'b0;
      else if (parity_bad)
        parity_err <= 1'b1;
      // a new framing error outranks the clear
      if (stop_bad)
        framing_error <= 1'b1;
      else if (clear_framing_error)
        framing_error <= 1'b0;
    end
  end

endmodule

/* src/uart_rx_top.sv */
module uart_rx_top
  import uart_frame_pkg::*;
(
  input  logic              clk,
  input  logic              aresetn,
  input  logic              baud_tick,
  input  logic              rx,
  input  logic              cfg_wr,
  input  logic              cfg_bit8,
  input  logic              cfg_parity_en,
  input  logic              cfg_odd,
  input  logic              read_rx_byte,
  input  logic              clear_parity,
  input  logic              clear_framing_error,
  output logic [DATA_W-1:0] rx_byte,
  output logic              receive_full,
  output logic              overflow,
  output logic              parity_err,
  output logic              framing_error
);

  logic              rx_filtered;
  logic              bit8;
  logic              parity_en;
  logic              odd;
  logic              frame_start;
  logic              sample_stb;
  logic              parity_stb;
  logic              byte_done;
  logic              stop_bad;
  logic [DATA_W-1:0] rx_data;
  logic              parity_bad;

  // --------------------
  // receive chain
  // --------------------

  rx_filter i_rx_filter (
    .clk         (clk),
    .aresetn     (aresetn),
    .baud_tick   (baud_tick),
    .rx          (rx),
    .rx_filtered (rx_filtered)
  );

  rx_frame_fsm i_rx_frame_fsm (
    .clk         (clk),
    .aresetn     (aresetn),
    .baud_tick   (baud_tick),
    .rx_filtered (rx_filtered),
    .bit8        (bit8),
    .parity_en   (parity_en),
    .frame_start (frame_start),
    .sample_stb  (sample_stb),
    .parity_stb  (parity_stb),
    .byte_done   (byte_done),
    .stop_bad    (stop_bad)
  );

  rx_data_path i_rx_data_path (
    .clk         (clk),
    .aresetn     (aresetn),
    .sample_stb  (sample_stb),
    .parity_stb  (parity_stb),
    .frame_start (frame_start),
    .rx_filtered (rx_filtered),
    .bit8        (bit8),
    .parity_en   (parity_en),
    .odd         (odd),
    .rx_data     (rx_data),
    .parity_bad  (parity_bad)
  );

  // --------------------
  // registers and flags
  // --------------------

  rx_ctrl_regs i_rx_ctrl_regs (
    .clk                 (clk),
    .aresetn             (aresetn),
    .cfg_wr              (cfg_wr),
    .cfg_bit8            (cfg_bit8),
    .cfg_parity_en       (cfg_parity_en),
    .cfg_odd             (cfg_odd),
    .byte_done           (byte_done),
    .rx_data             (rx_data),
    .parity_bad          (parity_bad),
    .stop_bad            (stop_bad),
    .read_rx_byte        (read_rx_byte),
    .clear_parity        (clear_parity),
    .clear_framing_error (clear_framing_error),
    .bit8                (bit8),
    .parity_en           (parity_en),
    .odd                 (odd),
    .rx_byte             (rx_byte),
    .receive_full        (receive_full),
    .overflow            (overflow),
    .parity_err          (parity_err),
    .framing_error       (framing_error)
  );

endmodule

/* test/tb_uart_rx.sv */
module tb_uart_rx
  import uart_frame_pkg::*;
();

  localparam int TICK_DIV    = 4;                          // clocks per baud tick
  localparam int BIT_CLK     = OVERSAMPLE * TICK_DIV;      // 64 clocks per bit
  localparam int FRAME_CLK   = (DATA_W + 3) * BIT_CLK;     // start, data, parity, stop
  localparam int GLITCH_AT   = (MID_START - 1) * TICK_DIV; // clock offset near mid bit
  localparam int TIMEOUT_CYC = 40000; // about 40 frames of FRAME_CLK plus margin

  logic              clk;
  logic              aresetn;
  logic              baud_tick = 1'b0;
  logic              rx;
  logic              cfg_wr;
  logic              cfg_bit8;
  logic              cfg_parity_en;
  logic              cfg_odd;
  logic              read_rx_byte;
  logic              clear_parity;
  logic              clear_framing_error;
  logic [DATA_W-1:0] rx_byte;
  logic              receive_full;
  logic              overflow;
  logic              parity_err;
  logic              framing_error;

  logic [1:0]        tick_div = 2'd0;
  logic              cur_bit8;          // format loaded in the DUT
  logic              cur_pe;
  logic              cur_odd;
  logic              par_model;         // sticky flags as the reference sees them
  logic              frm_model;
  logic [DATA_W-1:0] exp_byte_q[$];     // one entry per byte that should arrive
  logic              exp_perr_q[$];
  int                rd_idx      = 0;   // next entry for the checker
  logic              full_prev   = 1'b0;
  int                cycle_cnt   = 0;
  int                checks      = 0;
  int                rise_checks = 0;
  int                val_errs    = 0;
  int                other_errs  = 0;
  int                rise_errs   = 0;
  integer            seed        = 9729;

  uart_rx_top i_dut (
    .clk                 (clk),
    .aresetn             (aresetn),
    .baud_tick           (baud_tick),
    .rx                  (rx),
    .cfg_wr              (cfg_wr),
    .cfg_bit8            (cfg_bit8),
    .cfg_parity_en       (cfg_parity_en),
    .cfg_odd             (cfg_odd),
    .read_rx_byte        (read_rx_byte),
    .clear_parity        (clear_parity),
    .clear_framing_error (clear_framing_error),
    .rx_byte             (rx_byte),
    .receive_full        (receive_full),
    .overflow            (overflow),
    .parity_err          (parity_err),
    .framing_error       (framing_error)
  );

  // --------------------
  // clock, tick, timeout
  // --------------------

  always #5 clk = ~clk;

  always @(negedge clk)
  begin
    tick_div  = tick_div + 2'd1;
    baud_tick = (tick_div == 2'd0); // one clock in four
  end

  always @(posedge clk)
  begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYC)
    begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYC);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  // --------------------
  // compare on receive_full rising
  // --------------------

  always @(negedge clk)
  begin
    if (receive_full && !full_prev)
    begin
      if (rd_idx >= exp_byte_q.size())
      begin
        $display("receive_full rose at %0t with no byte expected", $time);
        rise_errs++;
      end
      else
      begin
        rise_checks += 2;
        if (rx_byte !== exp_byte_q[rd_idx])
        begin
          $display("ERROR rx_byte got 0x%02h expected 0x%02h", rx_byte, exp_byte_q[rd_idx]);
          rise_errs++;
        end
        if (parity_err !== exp_perr_q[rd_idx])
        begin
          $display("ERROR parity_err got 0x%0h expected 0x%0h", parity_err, exp_perr_q[rd_idx]);
          rise_errs++;
        end
        rd_idx++;
      end
    end
    full_prev = receive_full;
  end

  // expected {framing error, parity error, byte}
  function automatic logic [DATA_W+1:0] ref_frame(input logic [DATA_W-1:0] data,
                                                  input logic b8, input logic pe,
                                                  input logic bad_par, input logic bad_stop);
    logic [DATA_W-1:0] exp_byte;
    exp_byte = b8 ? data : {1'b0, data[DATA_W-2:0]}; // no top bit in 7-bit frames
    return {bad_stop, pe & bad_par, exp_byte};
  endfunction

  task automatic check_hex(input string name, input logic [7:0] got, input logic [7:0] exp);
    checks++;
    if (got !== exp)
    begin
      $display("ERROR %s got 0x%02h expected 0x%02h at %0t", name, got, exp, $time);
      val_errs++;
    end
  endtask

  // --------------------
  // stimulus tasks
  // --------------------

  task automatic set_format(input logic b8, input logic pe, input logic od);
    @(negedge clk);
    cfg_bit8      = b8;
    cfg_parity_en = pe;
    cfg_odd       = od;
    cfg_wr        = 1'b1;
    @(negedge clk) cfg_wr = 1'b0;
    cur_bit8 = b8;
    cur_pe   = pe;
    cur_odd  = od;
  endtask

  task automatic read_byte();
    @(negedge clk) read_rx_byte = 1'b1;
    @(negedge clk) read_rx_byte = 1'b0;
    check_hex("receive_full", {7'd0, receive_full}, 8'h00);
    check_hex("overflow", {7'd0, overflow}, 8'h00);
  endtask

  task automatic clear_parity_flag();
    @(negedge clk) clear_parity = 1'b1;
    @(negedge clk) clear_parity = 1'b0;
    par_model = 1'b0;
    check_hex("parity_err", {7'd0, parity_err}, 8'h00);
  endtask

  task automatic clear_framing_flag();
    @(negedge clk) clear_framing_error = 1'b1;
    @(negedge clk) clear_framing_error = 1'b0;
    frm_model = 1'b0;
    check_hex("framing_error", {7'd0, framing_error}, 8'h00);
  endtask

  task automatic idle_line(input int clocks);
    repeat (clocks)
    begin
      @(negedge clk);
      rx = LINE_IDLE;
    end
  endtask

  // start, data lsb first, optional parity, stop, then one idle bit
  task automatic send_frame(input logic [DATA_W-1:0] data, input logic bad_par,
                            input logic bad_stop, input int glitch_bit);
    logic              fbits[$];
    logic [DATA_W-1:0] d;
    logic              par;
    int                nb;
    int                c;
    nb  = cur_bit8 ? DATA_W : DATA_W - 1;
    d   = cur_bit8 ? data : {1'b0, data[DATA_W-2:0]};
    par = (^d) ^ cur_odd ^ bad_par; // even makes the ones count even
    fbits.push_back(LINE_START);
    repeat (nb)
    begin
      fbits.push_back(d[0]);
      d = d >> 1;
    end
    if (cur_pe)
      fbits.push_back(par);
    fbits.push_back(bad_stop ? LINE_START : LINE_IDLE);
    foreach (fbits[i])
    begin
      for (c = 0; c < BIT_CLK; c++)
      begin
        @(negedge clk);
        if (i == glitch_bit && c >= GLITCH_AT && c < GLITCH_AT + TICK_DIV)
          rx = ~fbits[i]; // spans exactly one tick
        else
          rx = fbits[i];
      end
    end
    idle_line(BIT_CLK);
  endtask

  task automatic run_frame(input logic [DATA_W-1:0] data, input logic bad_par,
                           input logic bad_stop, input int glitch_bit, input logic deliver);
    logic [DATA_W+1:0] r;
    int                waited;
    r         = ref_frame(data, cur_bit8, cur_pe, bad_par, bad_stop);
    par_model = par_model | r[DATA_W];
    frm_model = frm_model | r[DATA_W+1];
    if (deliver)
    begin
      exp_byte_q.push_back(r[DATA_W-1:0]);
      exp_perr_q.push_back(par_model);
    end
    send_frame(data, bad_par, bad_stop, glitch_bit);
    waited = 0;
    while (rd_idx < exp_byte_q.size() && waited < 2 * FRAME_CLK)
    begin
      @(negedge clk);
      waited++;
    end
    if (rd_idx < exp_byte_q.size())
    begin
      $display("receive_full did not rise within two frame times, byte 0x%02h lost",
               r[DATA_W-1:0]);
      other_errs++;
    end
    // second look once the stop bit has passed
    if (deliver)
    begin
      check_hex("rx_byte", rx_byte, r[DATA_W-1:0]);
      check_hex("receive_full", {7'd0, receive_full}, 8'h01);
      check_hex("overflow", {7'd0, overflow}, 8'h00); // register was empty
    end
    check_hex("parity_err", {7'd0, parity_err}, {7'd0, par_model});
    check_hex("framing_error", {7'd0, framing_error}, {7'd0, frm_model});
  endtask

  // --------------------
  // test sequence
  // --------------------

  initial
  begin
    logic [DATA_W-1:0] first_byte;
    int                k;
    clk                 = 1'b0;
    aresetn             = 1'b0;
    rx                  = LINE_IDLE;
    cfg_wr              = 1'b0;
    cfg_bit8            = 1'b1;
    cfg_parity_en       = 1'b0;
    cfg_odd             = 1'b0;
    read_rx_byte        = 1'b0;
    clear_parity        = 1'b0;
    clear_framing_error = 1'b0;
    cur_bit8            = 1'b1; // 8N1 out of reset
    cur_pe              = 1'b0;
    cur_odd             = 1'b0;
    par_model           = 1'b0;
    frm_model           = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk) aresetn = 1'b1;
    @(negedge clk);
    check_hex("rx_byte", rx_byte, 8'h00); // reset values
    check_hex("receive_full", {7'd0, receive_full}, 8'h00);
    check_hex("overflow", {7'd0, overflow}, 8'h00);
    check_hex("parity_err", {7'd0, parity_err}, 8'h00);
    check_hex("framing_error", {7'd0, framing_error}, 8'h00);

    set_format(1'b1, 1'b0, 1'b0); // 8N1 random bytes
    for (k = 0; k < 16; k++)
    begin
      run_frame(8'($random(seed)), 1'b0, 1'b0, -1, 1'b1);
      read_byte();
    end

    set_format(1'b0, 1'b1, 1'b0); // 7E1 with the error held until cleared
    run_frame(8'($random(seed)), 1'b0, 1'b0, -1, 1'b1);
    read_byte();
    run_frame(8'($random(seed)), 1'b1, 1'b0, -1, 1'b1);
    read_byte();
    run_frame(8'($random(seed)), 1'b0, 1'b0, -1, 1'b1);
    read_byte();
    clear_parity_flag();

    set_format(1'b1, 1'b1, 1'b1); // 8O1
    run_frame(8'($random(seed)), 1'b0, 1'b0, -1, 1'b1);
    read_byte();
    run_frame(8'($random(seed)), 1'b1, 1'b0, -1, 1'b1);
    read_byte();
    clear_parity_flag();

    set_format(1'b1, 1'b0, 1'b0); // low stop bit still delivers the byte
    run_frame(8'($random(seed)), 1'b0, 1'b1, -1, 1'b1);
    idle_line(BIT_CLK);
    clear_framing_flag();
    read_byte();

    first_byte = 8'($random(seed)); // second byte dropped while full
    run_frame(first_byte, 1'b0, 1'b0, -1, 1'b1);
    run_frame(~first_byte, 1'b0, 1'b0, -1, 1'b0);
    check_hex("rx_byte", rx_byte, first_byte);
    check_hex("receive_full", {7'd0, receive_full}, 8'h01);
    check_hex("overflow", {7'd0, overflow}, 8'h01);
    read_byte();

    @(negedge clk); // one-tick low on an idle line
    rx = LINE_START;
    repeat (TICK_DIV) @(negedge clk);
    rx = LINE_IDLE;
    idle_line(FRAME_CLK);
    check_hex("receive_full", {7'd0, receive_full}, 8'h00);
    check_hex("framing_error", {7'd0, framing_error}, 8'h00);
    run_frame(8'($random(seed)), 1'b0, 1'b0, 4, 1'b1); // glitch inside data bit 3
    read_byte();
    run_frame(8'($random(seed)), 1'b0, 1'b0, -1, 1'b1);
    read_byte();

    $display("checks: %0d, value errors: %0d, missing byte errors: %0d, checker errors: %0d",
             checks + rise_checks, val_errs, other_errs, rise_errs);
    if (val_errs + other_errs + rise_errs == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

/* verilog.f */
src/uart_frame_pkg.sv
src/uart_rx_pkg.sv
src/rx_filter.sv
src/rx_frame_fsm.sv
src/rx_data_path.sv
src/rx_ctrl_regs.sv
src/uart_rx_top.sv
test/tb_uart_rx.sv

/* run_sim.sh */
#!/bin/sh
# build tb_uart_rx with verilator, run it, decide pass or fail from the log
rm -rf obj_dir
verilator --binary -f verilog.f --top-module tb_uart_rx -o sim_uart_rx > build.log 2>&1 \
  && ./obj_dir/sim_uart_rx > sim.log 2>&1 \
  || { cat build.log sim.log 2>/dev/null; echo "build or simulation run failed"; exit 1; }
cat sim.log
grep -q "SOME TESTS FAILED" sim.log && { echo "simulation reported failures"; exit 1; }
echo "simulation passed"
exit 0
